// File: files.f
hdl/dbg_bus_pkg.sv
hdl/dbg_wb_bridge.sv
hdl/wb_arbiter.sv
hdl/wb_ram.sv
hdl/dbg_wb_subsys.sv
test/tb_clock_gen.sv
test/dbg_wb_assertions.sv
test/tb_dbg_wb_subsys.sv

// File: hdl/dbg_bus_pkg.sv
////////////////////////////////////////
// Wishbone single-cycle types, 32-bit data
// Little-endian lanes only, no burst tags
////////////////////////////////////////

package dbg_bus_pkg;

  ////////////////////////////////////////
  // Bus request and response
  ////////////////////////////////////////

  // One master's request
  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic        we;
    logic        cyc;
    logic        stb;
  } wb_req_t;

  // Slave reply, ack and err are exclusive
  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
    logic        err;
  } wb_rsp_t;

  // Data word as a whole or as byte lanes
  // Lane 0 is the least significant byte
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] lane;
  } bus_word_u;

  ////////////////////////////////////////
  // Debug access size codes
  ////////////////////////////////////////

  localparam logic [2:0] ACC_BYTE = 3'd1;
  localparam logic [2:0] ACC_HALF = 3'd2;
  // Any other code is treated as a word
  localparam logic [2:0] ACC_WORD = 3'd4;

endpackage

// File: hdl/dbg_wb_bridge.sv
////////////////////////////////////////
// Debug port to Wishbone, one access at a time
// Short write data must sit in the upper bits of data_i
////////////////////////////////////////

module dbg_wb_bridge (
  input  logic                  tck_i,
  input  logic                  wb_clk_i,
  input  logic                  rst_i,
  // Debug side, tck_i domain
  input  logic                  strobe_i,
  input  logic                  rd_wrn_i,
  input  logic [31:0]           addr_i,
  input  logic [31:0]           data_i,
  input  logic [2:0]            word_size_i,
  output logic                  rdy_o,
  output logic [31:0]           data_o,
  output logic                  err_o,
  // Bus side, wb_clk_i domain
  output dbg_bus_pkg::wb_req_t  wb_req_o,
  input  dbg_bus_pkg::wb_rsp_t  wb_rsp_i
);
  import dbg_bus_pkg::*;

  typedef enum logic {ST_IDLE, ST_XFER} state_t;

  // Latched access, stable long before the start toggle lands
  logic [31:0] addr_q;
  logic [31:0] wdat_q;
  logic [3:0]  sel_q;
  logic        we_q;

  // Toggle crossings
  logic        str_tgl;
  logic        str_ff1;
  logic        str_ff2;
  logic        str_ff2q;
  logic        done_tgl;
  logic        done_ff1;
  logic        done_ff2;
  logic        done_ff2q;

  logic        accept;
  logic [3:0]  be_dec;
  bus_word_u   wr_lanes;
  bus_word_u   rd_lanes;
  logic [31:0] rd_steer;
  logic [31:0] rdat_q;
  logic        err_q;
  logic        start_toggle;
  logic        active;
  logic        done;
  state_t      state_q;

  ////////////////////////////////////////
  // tck_i domain
  ////////////////////////////////////////

  assign accept = strobe_i && rdy_o;

  // Size and low address bits to byte enables
  // Write data moved from the top bits onto its lanes
  always_comb begin
    be_dec        = 4'b1111;
    wr_lanes.word = data_i;
    case (word_size_i)
      ACC_BYTE: begin
        be_dec                     = 4'b0001 << addr_i[1:0];
        wr_lanes.word              = '0;
        wr_lanes.lane[addr_i[1:0]] = data_i[31:24];
      end
      ACC_HALF: begin
        be_dec                            = addr_i[1] ? 4'b1100 : 4'b0011;
        wr_lanes.word                     = '0;
        // Half ignores addr_i[0]
        wr_lanes.lane[{addr_i[1], 1'b0}] = data_i[23:16];
        wr_lanes.lane[{addr_i[1], 1'b1}] = data_i[31:24];
      end
      default: begin
        be_dec        = 4'b1111;
        wr_lanes.word = data_i;
      end
    endcase
  end

  // Access capture
  always_ff @(posedge tck_i) begin
    if (accept) begin
      addr_q <= addr_i;
      wdat_q <= wr_lanes.word;
      sel_q  <= be_dec;
      we_q   <= ~rd_wrn_i;
    end
  end

  // Start toggle, done sync and ready flag
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      str_tgl   <= 1'b0;
      done_ff1  <= 1'b0;
      done_ff2  <= 1'b0;
      done_ff2q <= 1'b0;
      rdy_o     <= 1'b1;
    end else begin
      done_ff1  <= done_tgl;
      done_ff2  <= done_ff1;
      done_ff2q <= done_ff2;
      if (accept) begin
        str_tgl <= ~str_tgl;
        rdy_o   <= 1'b0;
      end else if (done_ff2 != done_ff2q) begin
        rdy_o <= 1'b1;
      end
    end
  end

  // Held since the done toggle, so safe to read in tck_i
  assign data_o = rdat_q;
  assign err_o  = err_q;

  ////////////////////////////////////////
  // wb_clk_i domain
  ////////////////////////////////////////

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      str_ff1  <= 1'b0;
      str_ff2  <= 1'b0;
      str_ff2q <= 1'b0;
    end else begin
      str_ff1  <= str_tgl;
      str_ff2  <= str_ff1;
      str_ff2q <= str_ff2;
    end
  end

  assign start_toggle = (str_ff2 != str_ff2q);

  // Bus request open from start until ack or err
  assign active = (state_q == ST_XFER) || start_toggle;
  assign done   = active && (wb_rsp_i.ack || wb_rsp_i.err);

  assign wb_req_o = '{adr: addr_q, dat: wdat_q, sel: sel_q, we: we_q,
                      cyc: active, stb: active};

  // Selected lanes down to bit 0, zero above
  assign rd_lanes = wb_rsp_i.dat;
  always_comb begin
    case (sel_q)
      4'b0001: rd_steer = {24'h0, rd_lanes.lane[0]};
      4'b0010: rd_steer = {24'h0, rd_lanes.lane[1]};
      4'b0100: rd_steer = {24'h0, rd_lanes.lane[2]};
      4'b1000: rd_steer = {24'h0, rd_lanes.lane[3]};
      4'b0011: rd_steer = {16'h0, rd_lanes.lane[1], rd_lanes.lane[0]};
      4'b1100: rd_steer = {16'h0, rd_lanes.lane[3], rd_lanes.lane[2]};
      default: rd_steer = rd_lanes.word;
    endcase
  end

  // Read data capture on ack
  always_ff @(posedge wb_clk_i) begin
    if (done && wb_rsp_i.ack && !we_q) begin
      rdat_q <= rd_steer;
    end
  end

  // FSM, error flag and done toggle
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q  <= ST_IDLE;
      err_q    <= 1'b0;
      done_tgl <= 1'b0;
    end else begin
      state_q <= (active && !done) ? ST_XFER : ST_IDLE;
      if (done) begin
        err_q    <= wb_rsp_i.err;
        done_tgl <= ~done_tgl;
      end
    end
  end

endmodule

// File: hdl/dbg_wb_subsys.sv
////////////////////////////////////////
// Debug bridge and system master sharing one RAM
// sys_req_i must follow the single-cycle rules of the bus
////////////////////////////////////////

module dbg_wb_subsys #(
  parameter int RAM_AW = 8
) (
  input  logic                 tck_i,
  input  logic                 wb_clk_i,
  input  logic                 rst_i,
  // Debug side
  input  logic                 strobe_i,
  input  logic                 rd_wrn_i,
  input  logic [31:0]          addr_i,
  input  logic [31:0]          data_i,
  input  logic [2:0]           word_size_i,
  output logic                 rdy_o,
  output logic [31:0]          data_o,
  output logic                 err_o,
  // System master port
  input  dbg_bus_pkg::wb_req_t sys_req_i,
  output dbg_bus_pkg::wb_rsp_t sys_rsp_o
);
  import dbg_bus_pkg::*;

  // Bridge is master 0, system port master 1
  wb_req_t m0_req;
  wb_rsp_t m0_rsp;
  wb_req_t s_req;
  wb_rsp_t s_rsp;

  dbg_wb_bridge u_bridge (
    .tck_i       (tck_i),
    .wb_clk_i    (wb_clk_i),
    .rst_i       (rst_i),
    .strobe_i    (strobe_i),
    .rd_wrn_i    (rd_wrn_i),
    .addr_i      (addr_i),
    .data_i      (data_i),
    .word_size_i (word_size_i),
    .rdy_o       (rdy_o),
    .data_o      (data_o),
    .err_o       (err_o),
    .wb_req_o    (m0_req),
    .wb_rsp_i    (m0_rsp)
  );

  wb_arbiter u_arb (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .m0_req_i (m0_req),
    .m1_req_i (sys_req_i),
    .m0_rsp_o (m0_rsp),
    .m1_rsp_o (sys_rsp_o),
    .s_req_o  (s_req),
    .s_rsp_i  (s_rsp)
  );

  wb_ram #(
    .RAM_AW (RAM_AW)
  ) u_ram (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .req_i    (s_req),
    .rsp_o    (s_rsp)
  );

endmodule

// File: hdl/wb_arbiter.sv
////////////////////////////////////////
// Two-master round-robin, grant kept while owner holds cyc
// Masters must hold their request until ack or err
////////////////////////////////////////

module wb_arbiter (
  input  logic                 wb_clk_i,
  input  logic                 rst_i,
  // Masters
  input  dbg_bus_pkg::wb_req_t m0_req_i,
  input  dbg_bus_pkg::wb_req_t m1_req_i,
  output dbg_bus_pkg::wb_rsp_t m0_rsp_o,
  output dbg_bus_pkg::wb_rsp_t m1_rsp_o,
  // Slave
  output dbg_bus_pkg::wb_req_t s_req_o,
  input  dbg_bus_pkg::wb_rsp_t s_rsp_i
);

  logic busy_q;
  // Owner and last winner, 1 means m1
  logic owner_q;
  logic last_q;
  logic hold;
  logic gnt_sel;
  logic gnt_valid;
  logic gnt_0;
  logic gnt_1;

  // Current owner still in its cycle
  assign hold = busy_q && (owner_q ? m1_req_i.cyc : m0_req_i.cyc);

  // Combinational grant, a lone requester goes straight through
  always_comb begin
    if (hold) begin
      gnt_sel = owner_q;
    end else if (m0_req_i.cyc && m1_req_i.cyc) begin
      // Both asking, the one not granted last wins
      gnt_sel = ~last_q;
    end else begin
      gnt_sel = m1_req_i.cyc;
    end
  end

  assign gnt_valid = hold || m0_req_i.cyc || m1_req_i.cyc;
  assign gnt_0     = gnt_valid && !gnt_sel;
  assign gnt_1     = gnt_valid && gnt_sel;

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
      // m0 wins the first tie
      last_q  <= 1'b1;
    end else begin
      busy_q  <= gnt_valid;
      owner_q <= gnt_sel;
      if (gnt_valid && !hold) begin
        last_q <= gnt_sel;
      end
    end
  end

  ////////////////////////////////////////
  // Request mux and response routing
  ////////////////////////////////////////

  assign s_req_o = gnt_sel ? m1_req_i : m0_req_i;

  // Read data shared, handshake to the owner only
  assign m0_rsp_o = '{dat: s_rsp_i.dat, ack: s_rsp_i.ack && gnt_0,
                      err: s_rsp_i.err && gnt_0};
  assign m1_rsp_o = '{dat: s_rsp_i.dat, ack: s_rsp_i.ack && gnt_1,
                      err: s_rsp_i.err && gnt_1};

endmodule

// File: hdl/wb_ram.sv
////////////////////////////////////////
// Byte-lane RAM of 2**RAM_AW words, reply one cycle after stb
// Words at or above the depth answer err
////////////////////////////////////////

module wb_ram #(
  parameter int RAM_AW = 8
) (
  input  logic                 wb_clk_i,
  input  logic                 rst_i,
  input  dbg_bus_pkg::wb_req_t req_i,
  output dbg_bus_pkg::wb_rsp_t rsp_o
);
  import dbg_bus_pkg::*;

  bus_word_u         mem [2**RAM_AW];
  bus_word_u         wdat;
  logic [RAM_AW-1:0] idx;
  logic              in_range;
  logic              take;
  logic [31:0]       rdat_q;
  logic              ack_q;
  logic              err_q;

  assign wdat     = req_i.dat;
  assign idx      = req_i.adr[RAM_AW+1:2];
  // Any address bit above the word index means out of range
  assign in_range = (req_i.adr[31:RAM_AW+2] == '0);

  // New request only, a held stb after a reply is ignored
  assign take = req_i.cyc && req_i.stb && !(ack_q || err_q);

  // Lane writes and read capture
  always_ff @(posedge wb_clk_i) begin
    if (take && in_range) begin
      rdat_q <= mem[idx].word;
      if (req_i.we) begin
        for (int i = 0; i < 4; i++) begin
          if (req_i.sel[i]) begin
            mem[idx].lane[i] <= wdat.lane[i];
          end
        end
      end
    end
  end

  // One-cycle reply, never two in a row
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= take && in_range;
      err_q <= take && !in_range;
    end
  end

  assign rsp_o = '{dat: rdat_q, ack: ack_q, err: err_q};

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run, success only if the log holds the pass line
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_dbg_wb_subsys -f files.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  exit 0
fi
exit 1

// File: test/dbg_wb_assertions.sv
////////////////////////////////////////
// Bus and arbiter rules, checked on wb_clk_i
// Reaches into the arbiter for its grant lines
////////////////////////////////////////

module dbg_wb_assertions (
  input logic                 wb_clk_i,
  input logic                 rst_i,
  input logic                 gnt_0_i,
  input logic                 gnt_1_i,
  input dbg_bus_pkg::wb_req_t s_req_i,
  input dbg_bus_pkg::wb_rsp_t s_rsp_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // One owner until the reply, grant never moves mid cycle
  a_single_grant: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    ((gnt_0_i || gnt_1_i) && !(s_rsp_i.ack || s_rsp_i.err))
    |=> (gnt_0_i == $past(gnt_0_i)) && (gnt_1_i == $past(gnt_1_i)))
    else $error("grant moved before reply");

  a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    !(s_rsp_i.ack && s_rsp_i.err))
    else $error("ack and err together");

  // A reply only while the owner still strobes
  a_rsp_needs_stb: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (s_rsp_i.ack || s_rsp_i.err) |-> s_req_i.stb)
    else $error("reply without stb");

  // Open request held until ack or err
  a_req_stable: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (s_req_i.cyc && s_req_i.stb && !(s_rsp_i.ack || s_rsp_i.err))
    |=> $stable(s_req_i))
    else $error("request changed before reply");

endmodule

bind dbg_wb_subsys dbg_wb_assertions u_assertions (
  .wb_clk_i (wb_clk_i),
  .rst_i    (rst_i),
  .gnt_0_i  (u_arb.gnt_0),
  .gnt_1_i  (u_arb.gnt_1),
  .s_req_i  (s_req),
  .s_rsp_i  (s_rsp)
);

// File: test/tb_clock_gen.sv
////////////////////////////////////////
// Free-running clock, starts low
// Half period is PERIOD_NS / 2 in whole ns
////////////////////////////////////////

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial clk_o = 1'b0;

  // First rising edge after half a period
  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// File: test/tb_dbg_wb_subsys.sv
////////////////////////////////////////
// Directed tests of debug port and system master
// RAM is X until written, so every read follows a write
////////////////////////////////////////

module tb_dbg_wb_subsys;
  timeunit 1ns;
  timeprecision 100ps;
  import dbg_bus_pkg::*;

  localparam int RAM_AW = 8;
  localparam int RAM_BYTES = 4 * (2 ** RAM_AW);
  // About 60 accesses at up to 40 wb_clk_i cycles each, plus margin
  localparam int ACCESSES = 60;
  localparam int CYCLES_PER_ACCESS = 40;
  localparam int MAX_CYCLES = ACCESSES * CYCLES_PER_ACCESS + 1600;

  logic        wb_clk_i;
  logic        tck_i;
  logic        rst_i;
  logic        strobe_i;
  logic        rd_wrn_i;
  logic [31:0] addr_i;
  logic [31:0] data_i;
  logic [2:0]  word_size_i;
  logic        rdy_o;
  logic [31:0] data_o;
  logic        err_o;
  wb_req_t     sys_req_i;
  wb_rsp_t     sys_rsp_o;

  // Byte image of the RAM, lane 0 at the lowest address
  logic [7:0]  model [RAM_BYTES];
  logic [31:0] lfsr_q = 32'hb6bc;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycles = 0;

  tb_clock_gen #(.PERIOD_NS(40)) u_wb_clk (.clk_o(wb_clk_i));
  tb_clock_gen #(.PERIOD_NS(100)) u_tck (.clk_o(tck_i));

  dbg_wb_subsys #(
    .RAM_AW (RAM_AW)
  ) DUT (
    .tck_i       (tck_i),
    .wb_clk_i    (wb_clk_i),
    .rst_i       (rst_i),
    .strobe_i    (strobe_i),
    .rd_wrn_i    (rd_wrn_i),
    .addr_i      (addr_i),
    .data_i      (data_i),
    .word_size_i (word_size_i),
    .rdy_o       (rdy_o),
    .data_o      (data_o),
    .err_o       (err_o),
    .sys_req_i   (sys_req_i),
    .sys_rsp_o   (sys_rsp_o)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Word aligned, inside the RAM
  function automatic logic [31:0] rand_addr();
    return rand_bits(RAM_AW) << 2;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %-12s %s", name, (test_errors == 0) ? "ok" : "had mismatches");
    test_errors = 0;
  endtask

  function automatic int byte_base(input logic [31:0] addr);
    return int'({addr[RAM_AW+1:2], 2'b00});
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] sel);
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        model[byte_base(addr) + i] = data[8*i +: 8];
      end
    end
  endtask

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    int b;
    b = byte_base(addr);
    return {model[b+3], model[b+2], model[b+1], model[b]};
  endfunction

  // Lanes covered by the access
  // It starts at the address rounded down to its size
  function automatic logic [3:0] lane_sel(input logic [31:0] addr, input logic [2:0] size);
    logic [3:0] sel;
    int         first;
    int         n;
    case (size)
      ACC_BYTE: n = 1;
      ACC_HALF: n = 2;
      default:  n = 4;
    endcase
    first = int'(addr[1:0]) - (int'(addr[1:0]) % n);
    for (int i = 0; i < 4; i++) begin
      sel[i] = (i >= first) && (i < first + n);
    end
    return sel;
  endfunction

  // Upper-aligned short data copied onto every candidate lane
  function automatic logic [31:0] lane_data(input logic [31:0] data, input logic [2:0] size);
    case (size)
      ACC_BYTE: return {4{data[31:24]}};
      ACC_HALF: return {2{data[31:16]}};
      default:  return data;
    endcase
  endfunction

  // Read result moved down to bit 0
  function automatic logic [31:0] lane_expect(input logic [31:0] addr, input logic [2:0] size);
    logic [31:0] w;
    w = model_word(addr);
    case (size)
      ACC_BYTE: return (w >> (8 * addr[1:0])) & 32'h0000_00ff;
      ACC_HALF: return (w >> (16 * addr[1])) & 32'h0000_ffff;
      default:  return w;
    endcase
  endfunction

  ////////////////////////////////////////
  // Bus drivers
  ////////////////////////////////////////

  // One debug access, sampled on the falling tck_i edge
  task automatic dbg_access(input logic rd, input logic [31:0] addr, input logic [31:0] data,
                            input logic [2:0] size, output logic [31:0] rdata,
                            output logic err);
    @(negedge tck_i);
    while (!rdy_o) @(negedge tck_i);
    @(posedge tck_i);
    strobe_i    <= 1'b1;
    rd_wrn_i    <= rd;
    addr_i      <= addr;
    data_i      <= data;
    word_size_i <= size;
    // Accepted on this edge
    @(posedge tck_i);
    strobe_i <= 1'b0;
    @(negedge tck_i);
    check("rdy_o", 32'(rdy_o), 32'h0);
    while (!rdy_o) @(negedge tck_i);
    rdata = data_o;
    err   = err_o;
  endtask

  task automatic dbg_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [2:0] size);
    logic [31:0] rdata;
    logic        err;
    dbg_access(1'b0, addr, data, size, rdata, err);
    check("err_o", 32'(err), 32'h0);
    model_write(addr, lane_data(data, size), lane_sel(addr, size));
  endtask

  task automatic dbg_read_check(input logic [31:0] addr, input logic [2:0] size);
    logic [31:0] rdata;
    logic        err;
    dbg_access(1'b1, addr, 32'h0, size, rdata, err);
    check("err_o", 32'(err), 32'h0);
    check("data_o", rdata, lane_expect(addr, size));
  endtask

  // One system cycle, cyc dropped on the edge after the reply
  task automatic sys_access(input logic we, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] sel, output logic [31:0] rdata,
                            output logic err);
    @(posedge wb_clk_i);
    sys_req_i <= '{adr: addr, dat: data, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
    @(negedge wb_clk_i);
    while (!(sys_rsp_o.ack || sys_rsp_o.err)) @(negedge wb_clk_i);
    rdata = sys_rsp_o.dat;
    err   = sys_rsp_o.err;
    @(posedge wb_clk_i);
    sys_req_i <= '0;
  endtask

  task automatic sys_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] sel);
    logic [31:0] rdata;
    logic        err;
    sys_access(1'b1, addr, data, sel, rdata, err);
    check("sys_rsp_o.err", 32'(err), 32'h0);
    model_write(addr, data, sel);
  endtask

  task automatic sys_read_check(input logic [31:0] addr);
    logic [31:0] rdata;
    logic        err;
    sys_access(1'b0, addr, 32'h0, 4'hf, rdata, err);
    check("sys_rsp_o.err", 32'(err), 32'h0);
    check("sys_rsp_o.dat", rdata, model_word(addr));
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic reset_state();
    @(negedge wb_clk_i);
    check("rdy_o", 32'(rdy_o), 32'h1);
    check("err_o", 32'(err_o), 32'h0);
    check("sys_rsp_o.ack", 32'(sys_rsp_o.ack), 32'h0);
    check("sys_rsp_o.err", 32'(sys_rsp_o.err), 32'h0);
    end_test("reset");
  endtask

  task automatic word_access();
    logic [31:0] a;
    for (int i = 0; i < 6; i++) begin
      a = rand_addr();
      dbg_write(a, rand_bits(32), ACC_WORD);
      dbg_read_check(a, ACC_WORD);
    end
    end_test("word");
  endtask

  // Word read after each short write shows the untouched lanes
  task automatic short_access();
    dbg_write(32'h40, rand_bits(32), ACC_WORD);
    for (int off = 0; off < 4; off++) begin
      dbg_write(32'h40 + off, rand_bits(32), ACC_BYTE);
      dbg_read_check(32'h40, ACC_WORD);
      dbg_read_check(32'h40 + off, ACC_BYTE);
    end
    dbg_write(32'h48, rand_bits(32), ACC_WORD);
    for (int off = 0; off < 4; off += 2) begin
      dbg_write(32'h48 + off, rand_bits(32), ACC_HALF);
      dbg_read_check(32'h48, ACC_WORD);
      dbg_read_check(32'h48 + off, ACC_HALF);
    end
    end_test("byte_half");
  endtask

  task automatic range_access();
    logic [31:0] oor;
    logic [31:0] rdata;
    logic        err;
    // Same word index as 0x20, one bit above the depth
    oor = 32'h20 | (32'h1 << (RAM_AW + 2));
    dbg_write(32'h20, rand_bits(32), ACC_WORD);
    dbg_access(1'b0, oor, rand_bits(32), ACC_WORD, rdata, err);
    check("err_o", 32'(err), 32'h1);
    dbg_access(1'b1, oor, 32'h0, ACC_WORD, rdata, err);
    check("err_o", 32'(err), 32'h1);
    // Unchanged word, and err_o cleared
    dbg_read_check(32'h20, ACC_WORD);
    end_test("range");
  endtask

  task automatic shared_bus();
    logic dbg_done;
    int   i;
    dbg_done = 1'b0;
    i = 0;
    sys_write(32'h80, rand_bits(32), 4'hf);
    dbg_read_check(32'h80, ACC_WORD);
    sys_write(32'h80, rand_bits(32), 4'b0110);
    dbg_read_check(32'h82, ACC_HALF);
    dbg_write(32'h84, rand_bits(32), ACC_WORD);
    sys_read_check(32'h84);
    // System master keeps asking while debug runs
    fork
      begin
        for (int k = 0; k < 3; k++) begin
          dbg_write(32'h100 + 4 * k, rand_bits(32), ACC_WORD);
          dbg_read_check(32'h100 + 4 * k, ACC_WORD);
        end
        dbg_done = 1'b1;
      end
      begin
        while (!dbg_done) begin
          sys_write(32'h200 + 4 * i, rand_bits(32), 4'hf);
          sys_read_check(32'h200 + 4 * i);
          i = (i + 1) % 8;
        end
      end
    join
    end_test("shared");
  endtask

  ////////////////////////////////////////
  // Run control
  ////////////////////////////////////////

  always @(posedge wb_clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d wb_clk_i cycles, an access never completed", MAX_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    rst_i       = 1'b1;
    strobe_i    = 1'b0;
    rd_wrn_i    = 1'b0;
    addr_i      = 32'h0;
    data_i      = 32'h0;
    word_size_i = 3'd0;
    sys_req_i   = '0;
    repeat (3) @(posedge wb_clk_i);
    rst_i <= 1'b0;
    reset_state();
    word_access();
    short_access();
    range_access();
    shared_bus();
    $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
